// ==== all.f ====
source/lq_pkg.sv
source/lq_pointers.sv
source/lq_entries.sv
source/lq_wb_select.sv
source/lq_violation_check.sv
source/load_queue.sv
tests/load_queue_tb.sv

// ==== run.sh ====
#!/bin/sh
# Builds the load queue testbench with Verilator and runs it.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module load_queue_tb \
    -f all.f -o sim_load_queue
status=$?
if [ "$status" -ne 0 ]; then
    echo "Verilator build failed."
    exit "$status"
fi

./obj_dir/sim_load_queue
status=$?
if [ "$status" -ne 0 ]; then
    echo "Simulation failed."
    exit "$status"
fi
exit 0

// ==== source/load_queue.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_queue import lq_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                dis_en,
    input  wire logic                commit_en,
    input  wire logic                ex_en,
    input  wire logic [LQ_POS_W-1:0] ex_pos,
    input  wire logic [ADDR_W-1:0]   ex_addr,
    input  wire logic [BYTE_N-1:0]   ex_mask,
    input  wire logic                ex_miss,
    input  wire logic [DATA_W-1:0]   ex_rdata,
    input  wire logic                refill_en,
    input  wire logic [LQ_IDX_W-1:0] refill_idx,
    input  wire logic [DATA_W-1:0]   refill_data,
    input  wire logic                wb_ready,
    input  wire logic                st_en,
    input  wire logic [LQ_POS_W-1:0] st_pos,
    input  wire logic [ADDR_W-1:0]   st_addr,
    input  wire logic [BYTE_N-1:0]   st_mask,
    output logic      [LQ_POS_W-1:0] dis_pos,
    output logic                     full,
    output logic                     wb_en,
    output logic      [LQ_IDX_W-1:0] wb_idx,
    output logic      [DATA_W-1:0]   wb_data,
    output logic                     vio_en,
    output logic      [LQ_POS_W-1:0] vio_pos
);

    logic [LQ_POS_W-1:0] head_pos;
    logic [LQ_POS_W-1:0] tail_pos;
    logic [LQ_SIZE-1:0]  entry_valid;
    logic [LQ_SIZE-1:0]  waiting;
    logic [LQ_IDX_W-1:0] rd_idx;
    logic [DATA_W-1:0]   rd_data;
    logic                wb_accept;

    assign dis_pos = tail_pos; // The new load takes the tail slot.

    lq_pointers pointers_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .dis_en    (dis_en),
        .commit_en (commit_en),
        .head_pos  (head_pos),
        .tail_pos  (tail_pos),
        .full      (full)
    );

    lq_entries entries_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .dis_en      (dis_en),
        .tail_pos    (tail_pos),
        .commit_en   (commit_en),
        .head_pos    (head_pos),
        .ex_en       (ex_en),
        .ex_pos      (ex_pos),
        .ex_miss     (ex_miss),
        .ex_mask     (ex_mask),
        .ex_rdata    (ex_rdata),
        .refill_en   (refill_en),
        .refill_idx  (refill_idx),
        .refill_data (refill_data),
        .wb_accept   (wb_accept),
        .wb_idx      (wb_idx),
        .rd_idx      (rd_idx),
        .entry_valid (entry_valid),
        .waiting     (waiting),
        .rd_data     (rd_data)
    );

    lq_wb_select wb_select_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .waiting   (waiting),
        .head_pos  (head_pos),
        .tail_pos  (tail_pos),
        .rd_data   (rd_data),
        .wb_ready  (wb_ready),
        .rd_idx    (rd_idx),
        .wb_accept (wb_accept),
        .wb_en     (wb_en),
        .wb_idx    (wb_idx),
        .wb_data   (wb_data)
    );

    lq_violation_check violation_check_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .ex_en       (ex_en),
        .ex_pos      (ex_pos),
        .ex_addr     (ex_addr),
        .ex_mask     (ex_mask),
        .dis_en      (dis_en),
        .tail_pos    (tail_pos),
        .entry_valid (entry_valid),
        .st_en       (st_en),
        .st_pos      (st_pos),
        .st_addr     (st_addr),
        .st_mask     (st_mask),
        .vio_en      (vio_en),
        .vio_pos     (vio_pos)
    );

endmodule

`default_nettype wire

// ==== source/lq_entries.sv ====
`timescale 1ns/1ps
`default_nettype none

module lq_entries import lq_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                dis_en,
    input  wire logic [LQ_POS_W-1:0] tail_pos,
    input  wire logic                commit_en,
    input  wire logic [LQ_POS_W-1:0] head_pos,
    input  wire logic                ex_en,
    input  wire logic [LQ_POS_W-1:0] ex_pos,
    input  wire logic                ex_miss,
    input  wire logic [BYTE_N-1:0]   ex_mask,
    input  wire logic [DATA_W-1:0]   ex_rdata,
    input  wire logic                refill_en,
    input  wire logic [LQ_IDX_W-1:0] refill_idx,
    input  wire logic [DATA_W-1:0]   refill_data,
    input  wire logic                wb_accept,
    input  wire logic [LQ_IDX_W-1:0] wb_idx,
    input  wire logic [LQ_IDX_W-1:0] rd_idx,
    output logic      [LQ_SIZE-1:0]  entry_valid,
    output logic      [LQ_SIZE-1:0]  waiting,
    output logic      [DATA_W-1:0]   rd_data
);

    logic [LQ_SIZE-1:0]  valid;
    logic [LQ_SIZE-1:0]  missed;
    logic [LQ_SIZE-1:0]  data_valid;
    logic [LQ_SIZE-1:0]  written_back;
    logic [DATA_W-1:0]   data_q [LQ_SIZE];
    logic [BYTE_N-1:0]   mask_q [LQ_SIZE];
    logic [DATA_W-1:0]   keep_bits;
    logic [DATA_W-1:0]   merged;
    logic [LQ_IDX_W-1:0] ex_idx;

    assign ex_idx = ex_pos[LQ_IDX_W-1:0];

    // Forwarded bytes survive the refill, everything else comes from the cache line.
    always_comb begin
        for (int b = 0; b < BYTE_N; b++) begin
            keep_bits[b*8 +: 8] = {8{mask_q[refill_idx][b]}};
        end
    end
    assign merged = (data_q[refill_idx] & keep_bits) | (refill_data & ~keep_bits);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            valid        <= '0;
            missed       <= '0;
            data_valid   <= '0;
            written_back <= '0;
        end else begin
            if (dis_en) begin
                valid[tail_pos[LQ_IDX_W-1:0]]        <= 1'b1;
                missed[tail_pos[LQ_IDX_W-1:0]]       <= 1'b0;
                data_valid[tail_pos[LQ_IDX_W-1:0]]   <= 1'b0;
                written_back[tail_pos[LQ_IDX_W-1:0]] <= 1'b0;
            end
            if (ex_en) begin
                missed[ex_idx]       <= ex_miss;
                data_valid[ex_idx]   <= ~ex_miss;
                written_back[ex_idx] <= ~ex_miss; // A hit goes back through the load pipeline.
            end
            if (wb_accept) begin
                written_back[wb_idx] <= 1'b1;
            end
            if (commit_en) begin
                valid[head_pos[LQ_IDX_W-1:0]] <= 1'b0;
            end
            if (refill_en) begin
                data_valid[refill_idx] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_en) begin
            data_q[ex_idx] <= ex_rdata;
            mask_q[ex_idx] <= ex_mask;
        end
        if (refill_en) begin
            data_q[refill_idx] <= merged;
        end
    end

    assign entry_valid = valid;
    assign waiting     = valid & missed & data_valid & ~written_back;
    assign rd_data     = data_q[rd_idx];

    // The refill must match a miss that the load pipeline reported earlier.
    a_refill_target: assert property (
        @(posedge clk) disable iff (!rst_n)
        refill_en |-> valid[refill_idx] && missed[refill_idx] && !data_valid[refill_idx]
    ) else $error("Refill for an entry that is not waiting on the cache.");

endmodule

`default_nettype wire

// ==== source/lq_pkg.sv ====
`default_nettype none

package lq_pkg;

    localparam int LQ_SIZE  = 8;
    localparam int LQ_IDX_W = 3;
    localparam int LQ_POS_W = LQ_IDX_W + 1; // Index plus wrap bit.
    localparam int ADDR_W   = 32;
    localparam int DATA_W   = 32;
    localparam int BYTE_N   = DATA_W / 8;

    // Entries from start_pos up to but not including end_pos, in queue order.
    // Equal indices mean an empty window when the wrap bits match and a full one otherwise.
    function automatic logic [LQ_SIZE-1:0] lq_age_window(
        input logic [LQ_POS_W-1:0] start_pos,
        input logic [LQ_POS_W-1:0] end_pos
    );
        logic [LQ_SIZE-1:0] start_mask;
        logic [LQ_SIZE-1:0] end_mask;
        logic               span;
        for (int i = 0; i < LQ_SIZE; i++) begin
            start_mask[i] = (i < start_pos[LQ_IDX_W-1:0]);
            end_mask[i]   = (i < end_pos[LQ_IDX_W-1:0]);
        end
        span = start_pos[LQ_IDX_W] ^ end_pos[LQ_IDX_W];
        return span ? ~(start_mask ^ end_mask) : (start_mask ^ end_mask);
    endfunction

endpackage

`default_nettype wire

// ==== source/lq_pointers.sv ====
`timescale 1ns/1ps
`default_nettype none

module lq_pointers import lq_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                dis_en,
    input  wire logic                commit_en,
    output logic      [LQ_POS_W-1:0] head_pos,
    output logic      [LQ_POS_W-1:0] tail_pos,
    output logic                     full
);

    logic empty;

    // The wrap bit sits right above the index, so a plain increment flips it on rollover.
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            head_pos <= '0;
            tail_pos <= '0;
        end else begin
            if (commit_en) begin
                head_pos <= head_pos + LQ_POS_W'(1);
            end
            if (dis_en) begin
                tail_pos <= tail_pos + LQ_POS_W'(1);
            end
        end
    end

    assign empty = (head_pos == tail_pos);
    assign full  = (head_pos[LQ_IDX_W-1:0] == tail_pos[LQ_IDX_W-1:0]) &&
                   (head_pos[LQ_IDX_W] != tail_pos[LQ_IDX_W]);

    a_no_dispatch_when_full: assert property (
        @(posedge clk) disable iff (!rst_n) dis_en |-> !full
    ) else $error("Load dispatched while the queue is full.");

    a_no_commit_when_empty: assert property (
        @(posedge clk) disable iff (!rst_n) commit_en |-> !empty
    ) else $error("Load committed while the queue is empty.");

endmodule

`default_nettype wire

// ==== source/lq_violation_check.sv ====
`timescale 1ns/1ps
`default_nettype none

module lq_violation_check import lq_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic                ex_en,
    input  wire logic [LQ_POS_W-1:0] ex_pos,
    input  wire logic [ADDR_W-1:0]   ex_addr,
    input  wire logic [BYTE_N-1:0]   ex_mask,
    input  wire logic                dis_en,
    input  wire logic [LQ_POS_W-1:0] tail_pos,
    input  wire logic [LQ_SIZE-1:0]  entry_valid,
    input  wire logic                st_en,
    input  wire logic [LQ_POS_W-1:0] st_pos,
    input  wire logic [ADDR_W-1:0]   st_addr,
    input  wire logic [BYTE_N-1:0]   st_mask,
    output logic                     vio_en,
    output logic      [LQ_POS_W-1:0] vio_pos
);

    logic [ADDR_W-3:0]   word_q [LQ_SIZE];
    logic [BYTE_N-1:0]   mask_q [LQ_SIZE];
    logic [LQ_SIZE-1:0]  executed;
    logic [LQ_SIZE-1:0]  hit_vec;
    logic [LQ_SIZE-1:0]  cmp_q;
    logic [LQ_POS_W-1:0] st_pos_q;
    logic [LQ_SIZE-1:0]  at_or_after;
    logic [LQ_SIZE-1:0]  upper_hits;
    logic [LQ_IDX_W-1:0] enc_idx;
    logic                enc_wrap;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            executed <= '0;
        end else begin
            if (dis_en) begin
                executed[tail_pos[LQ_IDX_W-1:0]] <= 1'b0;
            end
            if (ex_en) begin
                executed[ex_pos[LQ_IDX_W-1:0]] <= 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (ex_en) begin
            word_q[ex_pos[LQ_IDX_W-1:0]] <= ex_addr[ADDR_W-1:2];
            mask_q[ex_pos[LQ_IDX_W-1:0]] <= ex_mask;
        end
    end

    // Only loads younger than the store and already executed can have read stale data.
    always_comb begin
        for (int j = 0; j < LQ_SIZE; j++) begin
            hit_vec[j] = st_en & entry_valid[j] & executed[j] &
                         (word_q[j] == st_addr[ADDR_W-1:2]) & (|(mask_q[j] & st_mask));
        end
        hit_vec = hit_vec & lq_age_window(st_pos, tail_pos);
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            cmp_q <= '0;
        end else begin
            cmp_q <= hit_vec;
        end
    end

    always_ff @(posedge clk) begin
        st_pos_q <= st_pos;
    end

    always_comb begin
        for (int j = 0; j < LQ_SIZE; j++) begin
            at_or_after[j] = (j >= st_pos_q[LQ_IDX_W-1:0]);
        end
    end

    // Hits below the store index belong to the next lap of the queue.
    always_comb begin
        upper_hits = cmp_q & at_or_after;
        enc_idx    = '0;
        enc_wrap   = st_pos_q[LQ_IDX_W];
        if (|upper_hits) begin
            for (int j = LQ_SIZE - 1; j >= 0; j--) begin
                if (upper_hits[j]) enc_idx = LQ_IDX_W'(j);
            end
        end else begin
            enc_wrap = ~st_pos_q[LQ_IDX_W];
            for (int j = LQ_SIZE - 1; j >= 0; j--) begin
                if (cmp_q[j]) enc_idx = LQ_IDX_W'(j);
            end
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            vio_en <= 1'b0;
        end else begin
            vio_en <= |cmp_q;
        end
    end

    always_ff @(posedge clk) begin
        vio_pos <= {enc_wrap, enc_idx};
    end

    a_vio_pulse: assert property (
        @(posedge clk) disable iff (!rst_n) vio_en |=> !vio_en
    ) else $error("Violation report held for more than one cycle.");

endmodule

`default_nettype wire

// ==== source/lq_wb_select.sv ====
`timescale 1ns/1ps
`default_nettype none

module lq_wb_select import lq_pkg::*; (
    input  wire logic                clk,
    input  wire logic                rst_n,
    input  wire logic [LQ_SIZE-1:0]  waiting,
    input  wire logic [LQ_POS_W-1:0] head_pos,
    input  wire logic [LQ_POS_W-1:0] tail_pos,
    input  wire logic [DATA_W-1:0]   rd_data,
    input  wire logic                wb_ready,
    output logic      [LQ_IDX_W-1:0] rd_idx,
    output logic                     wb_accept,
    output logic                     wb_en,
    output logic      [LQ_IDX_W-1:0] wb_idx,
    output logic      [DATA_W-1:0]   wb_data
);

    logic [LQ_SIZE-1:0]  accept_vec;
    logic [LQ_SIZE-1:0]  cand;
    logic [LQ_IDX_W-1:0] scan_idx;
    logic [LQ_IDX_W-1:0] pick_idx;
    logic                pick_found;
    logic                hold;

    assign wb_accept  = wb_en & wb_ready;
    assign hold       = wb_en & ~wb_ready;
    assign accept_vec = wb_accept ? (LQ_SIZE'(1) << wb_idx) : '0;
    assign cand       = waiting & lq_age_window(head_pos, tail_pos) & ~accept_vec;

    // Scan from the youngest offset down so the entry nearest head wins.
    always_comb begin
        pick_idx   = head_pos[LQ_IDX_W-1:0];
        pick_found = 1'b0;
        scan_idx   = head_pos[LQ_IDX_W-1:0];
        for (int k = LQ_SIZE - 1; k >= 0; k--) begin
            scan_idx = head_pos[LQ_IDX_W-1:0] + LQ_IDX_W'(k);
            if (cand[scan_idx]) begin
                pick_idx   = scan_idx;
                pick_found = 1'b1;
            end
        end
    end

    assign rd_idx = pick_idx;

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wb_en <= 1'b0;
        end else if (!hold) begin
            wb_en <= pick_found;
        end
    end

    always_ff @(posedge clk) begin
        if (!hold) begin
            wb_idx  <= pick_idx;
            wb_data <= rd_data;
        end
    end

    a_wb_hold: assert property (
        @(posedge clk) disable iff (!rst_n)
        hold |=> wb_en && $stable(wb_idx) && $stable(wb_data)
    ) else $error("Writeback output changed under back-pressure.");

endmodule

`default_nettype wire

// ==== tests/load_queue_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

module load_queue_tb;

    localparam int MAX_ROWS = 128;

    localparam logic [2:0] OP_IDLE   = 3'd0;
    localparam logic [2:0] OP_DIS    = 3'd1;
    localparam logic [2:0] OP_COMMIT = 3'd2;
    localparam logic [2:0] OP_EX     = 3'd3;
    localparam logic [2:0] OP_REFILL = 3'd4;
    localparam logic [2:0] OP_STORE  = 3'd5;

    // One row is one cycle of stimulus plus the outputs expected during that cycle.
    typedef struct packed {
        logic [2:0]  op;
        logic [3:0]  pos;
        logic [2:0]  idx;
        logic [31:0] addr;
        logic [3:0]  mask;
        logic        miss;
        logic [31:0] data;
        logic        ready;
        logic        e_full;
        logic [3:0]  e_dis_pos;
        logic        c_wb;
        logic        e_wb_en;
        logic [2:0]  e_wb_idx;
        logic [31:0] e_wb_data;
        logic        c_vio;
        logic        e_vio_en;
        logic [3:0]  e_vio_pos;
    } row_t;

    logic        clk;
    logic        rst_n;
    logic        dis_en;
    logic        commit_en;
    logic        ex_en;
    logic [3:0]  ex_pos;
    logic [31:0] ex_addr;
    logic [3:0]  ex_mask;
    logic        ex_miss;
    logic [31:0] ex_rdata;
    logic        refill_en;
    logic [2:0]  refill_idx;
    logic [31:0] refill_data;
    logic        wb_ready;
    logic        st_en;
    logic [3:0]  st_pos;
    logic [31:0] st_addr;
    logic [3:0]  st_mask;
    logic [3:0]  dis_pos;
    logic        full;
    logic        wb_en;
    logic [2:0]  wb_idx;
    logic [31:0] wb_data;
    logic        vio_en;
    logic [3:0]  vio_pos;

    row_t        rows [MAX_ROWS];
    string       row_name [MAX_ROWS];
    int          n_rows = 0;
    int          cycle_count = 0;
    string       cur_test;
    logic        ready_level;
    logic [3:0]  model_head;
    logic [3:0]  model_tail;
    logic [31:0] lfsr_state = 32'hdbbd_53f0;

    load_queue load_queue_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .dis_en      (dis_en),
        .commit_en   (commit_en),
        .ex_en       (ex_en),
        .ex_pos      (ex_pos),
        .ex_addr     (ex_addr),
        .ex_mask     (ex_mask),
        .ex_miss     (ex_miss),
        .ex_rdata    (ex_rdata),
        .refill_en   (refill_en),
        .refill_idx  (refill_idx),
        .refill_data (refill_data),
        .wb_ready    (wb_ready),
        .st_en       (st_en),
        .st_pos      (st_pos),
        .st_addr     (st_addr),
        .st_mask     (st_mask),
        .dis_pos     (dis_pos),
        .full        (full),
        .wb_en       (wb_en),
        .wb_idx      (wb_idx),
        .wb_data     (wb_data),
        .vio_en      (vio_en),
        .vio_pos     (vio_pos)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    // Taps 32, 22, 2 and 1.
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic draw_word(output logic [31:0] w);
        w = '0;
        for (int b = 0; b < 32; b++) begin
            lfsr_state = lfsr_next(lfsr_state);
            w = {w[30:0], lfsr_state[0]};
        end
    endtask

    // Bytes marked in the mask were forwarded from stores, the others come from the refill.
    function automatic logic [31:0] expected_merge(input logic [31:0] fwd, input logic [3:0] mask,
                                                   input logic [31:0] fill);
        logic [31:0] word;
        for (int b = 0; b < 4; b++) begin
            word[b*8 +: 8] = mask[b] ? fwd[b*8 +: 8] : fill[b*8 +: 8];
        end
        return word;
    endfunction

    task automatic add_row(input logic [2:0] op, input logic [3:0] pos, input logic [31:0] addr,
                           input logic [3:0] mask, input logic miss, input logic [31:0] data);
        row_t r;
        r           = '0;
        r.op        = op;
        r.pos       = pos;
        r.idx       = pos[2:0];
        r.addr      = addr;
        r.mask      = mask;
        r.miss      = miss;
        r.data      = data;
        r.ready     = ready_level;
        r.e_full    = ((model_tail - model_head) == 4'd8);
        r.e_dis_pos = model_tail;
        rows[n_rows]     = r;
        row_name[n_rows] = cur_test;
        n_rows++;
        if (op == OP_DIS) model_tail = model_tail + 4'd1;
        if (op == OP_COMMIT) model_head = model_head + 4'd1;
    endtask

    task automatic idle_cycle();
        add_row(OP_IDLE, 4'd0, 32'd0, 4'd0, 1'b0, 32'd0);
    endtask

    task automatic dispatch_load();
        add_row(OP_DIS, 4'd0, 32'd0, 4'd0, 1'b0, 32'd0);
    endtask

    task automatic commit_load();
        add_row(OP_COMMIT, 4'd0, 32'd0, 4'd0, 1'b0, 32'd0);
    endtask

    task automatic execute_load(input logic [3:0] pos, input logic [31:0] addr,
                                input logic [3:0] mask, input logic miss, input logic [31:0] data);
        add_row(OP_EX, pos, addr, mask, miss, data);
    endtask

    task automatic refill_load(input logic [2:0] idx, input logic [31:0] data);
        add_row(OP_REFILL, {1'b0, idx}, 32'd0, 4'd0, 1'b0, data);
    endtask

    task automatic check_store(input logic [3:0] pos, input logic [31:0] addr,
                               input logic [3:0] mask);
        add_row(OP_STORE, pos, addr, mask, 1'b0, 32'd0);
    endtask

    task automatic expect_wb(input logic en, input logic [2:0] idx, input logic [31:0] data);
        rows[n_rows-1].c_wb      = 1'b1;
        rows[n_rows-1].e_wb_en   = en;
        rows[n_rows-1].e_wb_idx  = idx;
        rows[n_rows-1].e_wb_data = data;
    endtask

    task automatic expect_vio(input logic en, input logic [3:0] pos);
        rows[n_rows-1].c_vio     = 1'b1;
        rows[n_rows-1].e_vio_en  = en;
        rows[n_rows-1].e_vio_pos = pos;
    endtask

    // The report lands on the second cycle after the store row.
    task automatic store_and_watch(input logic [3:0] pos, input logic [31:0] addr,
                                   input logic [3:0] mask, input logic hit,
                                   input logic [3:0] oldest);
        check_store(pos, addr, mask);
        idle_cycle();
        expect_vio(1'b0, 4'd0);
        idle_cycle();
        expect_vio(hit, oldest);
        idle_cycle();
        expect_vio(1'b0, 4'd0);
    endtask

    task automatic build_table();
        logic [31:0] fwd_a;
        logic [31:0] fill_a;
        logic [31:0] fwd_e;
        logic [31:0] fwd_c;
        logic [31:0] fwd_d;
        logic [31:0] fill_e;
        logic [31:0] fill_c;
        logic [31:0] fill_d;
        logic [31:0] word;
        logic [3:0]  p0;
        logic [3:0]  p1;
        logic [3:0]  p2;
        logic [3:0]  p3;
        model_head  = 4'd0;
        model_tail  = 4'd0;
        ready_level = 1'b1;

        cur_test = "reset";
        idle_cycle();
        expect_wb(1'b0, 3'd0, 32'd0);
        expect_vio(1'b0, 4'd0);

        cur_test = "fill";
        for (int k = 0; k < 8; k++) begin
            dispatch_load();
        end
        idle_cycle();
        commit_load();
        dispatch_load(); // Gets index 0 with the wrap bit set.
        idle_cycle();
        for (int k = 0; k < 8; k++) begin
            commit_load();
        end

        cur_test = "refill_merge";
        p0 = model_tail;
        p1 = model_tail + 4'd1;
        dispatch_load();
        dispatch_load();
        draw_word(fwd_a);
        execute_load(p0, 32'h0000_1000, 4'b0011, 1'b1, fwd_a);
        draw_word(word);
        execute_load(p1, 32'h0000_1004, 4'b1111, 1'b0, word);
        expect_wb(1'b0, 3'd0, 32'd0);
        draw_word(fill_a);
        refill_load(p0[2:0], fill_a);
        expect_wb(1'b0, 3'd0, 32'd0);
        idle_cycle();
        expect_wb(1'b0, 3'd0, 32'd0);
        idle_cycle();
        expect_wb(1'b1, p0[2:0], expected_merge(fwd_a, 4'b0011, fill_a));
        idle_cycle();
        expect_wb(1'b0, 3'd0, 32'd0);
        idle_cycle();
        expect_wb(1'b0, 3'd0, 32'd0); // The hit load stays off writeback.
        commit_load();
        commit_load();

        cur_test = "store_check";
        p0 = model_tail;
        p1 = model_tail + 4'd1;
        p2 = model_tail + 4'd2;
        for (int k = 0; k < 3; k++) begin
            dispatch_load();
        end
        draw_word(word);
        execute_load(p0, 32'h0000_0100, 4'b1111, 1'b0, word);
        draw_word(word);
        execute_load(p1, 32'h0000_0100, 4'b0011, 1'b0, word);
        draw_word(word);
        execute_load(p2, 32'h0000_0102, 4'b0110, 1'b0, word);
        store_and_watch(p1, 32'h0000_0100, 4'b0010, 1'b1, p1);
        cur_test = "store_disjoint";
        store_and_watch(p1, 32'h0000_0100, 4'b1000, 1'b0, 4'd0);
        cur_test = "store_other_word";
        store_and_watch(p1, 32'h0000_0200, 4'b0010, 1'b0, 4'd0);
        cur_test = "store_older_loads";
        store_and_watch(model_tail, 32'h0000_0100, 4'b1111, 1'b0, 4'd0);
        for (int k = 0; k < 3; k++) begin
            commit_load();
        end

        cur_test = "wrap_store";
        p0 = model_tail;
        p1 = model_tail + 4'd1;
        p2 = model_tail + 4'd2;
        p3 = model_tail + 4'd3;
        for (int k = 0; k < 4; k++) begin
            dispatch_load();
        end
        draw_word(word);
        execute_load(p0, 32'h0000_0300, 4'b1111, 1'b0, word);
        draw_word(word);
        execute_load(p1, 32'h0000_0300, 4'b0001, 1'b0, word);
        draw_word(word);
        execute_load(p2, 32'h0000_0300, 4'b0010, 1'b0, word);
        draw_word(word);
        execute_load(p3, 32'h0000_0300, 4'b0100, 1'b0, word);
        store_and_watch(p1, 32'h0000_0300, 4'b0110, 1'b1, p2);
        store_and_watch(p1, 32'h0000_0300, 4'b0011, 1'b1, p1);
        for (int k = 0; k < 4; k++) begin
            commit_load();
        end

        cur_test = "wb_order";
        ready_level = 1'b0;
        p0 = model_tail;
        p1 = model_tail + 4'd1;
        p2 = model_tail + 4'd2;
        for (int k = 0; k < 3; k++) begin
            dispatch_load();
        end
        draw_word(fwd_e);
        execute_load(p0, 32'h0000_0400, 4'b0001, 1'b1, fwd_e);
        draw_word(fwd_c);
        execute_load(p1, 32'h0000_0404, 4'b0100, 1'b1, fwd_c);
        draw_word(fwd_d);
        execute_load(p2, 32'h0000_0408, 4'b1000, 1'b1, fwd_d);
        draw_word(fill_e);
        refill_load(p0[2:0], fill_e);
        expect_wb(1'b0, 3'd0, 32'd0);
        draw_word(fill_d);
        refill_load(p2[2:0], fill_d); // Younger one first.
        expect_wb(1'b0, 3'd0, 32'd0);
        draw_word(fill_c);
        refill_load(p1[2:0], fill_c);
        expect_wb(1'b1, p0[2:0], expected_merge(fwd_e, 4'b0001, fill_e));
        idle_cycle();
        expect_wb(1'b1, p0[2:0], expected_merge(fwd_e, 4'b0001, fill_e));
        idle_cycle();
        expect_wb(1'b1, p0[2:0], expected_merge(fwd_e, 4'b0001, fill_e));
        ready_level = 1'b1;
        idle_cycle();
        expect_wb(1'b1, p0[2:0], expected_merge(fwd_e, 4'b0001, fill_e));
        idle_cycle();
        expect_wb(1'b1, p1[2:0], expected_merge(fwd_c, 4'b0100, fill_c));
        idle_cycle();
        expect_wb(1'b1, p2[2:0], expected_merge(fwd_d, 4'b1000, fill_d));
        idle_cycle();
        expect_wb(1'b0, 3'd0, 32'd0);
        idle_cycle();
        expect_wb(1'b0, 3'd0, 32'd0);
        for (int k = 0; k < 3; k++) begin
            commit_load();
        end
    endtask

    task automatic drive_row(input row_t r);
        dis_en      <= (r.op == OP_DIS);
        commit_en   <= (r.op == OP_COMMIT);
        ex_en       <= (r.op == OP_EX);
        ex_pos      <= r.pos;
        ex_addr     <= r.addr;
        ex_mask     <= r.mask;
        ex_miss     <= r.miss;
        ex_rdata    <= r.data;
        refill_en   <= (r.op == OP_REFILL);
        refill_idx  <= r.idx;
        refill_data <= r.data;
        st_en       <= (r.op == OP_STORE);
        st_pos      <= r.pos;
        st_addr     <= r.addr;
        st_mask     <= r.mask;
        wb_ready    <= r.ready;
    endtask

    task automatic check_value(input string name, input logic [31:0] expected,
                               input logic [31:0] actual);
        if (expected !== actual) begin
            $display("FAIL %s: expected %0h, actual %0h", name, expected, actual);
            $display("Simulation finished: FAIL");
            $fatal(1, "Output mismatch.");
        end
    endtask

    task automatic check_row(input int i);
        row_t r;
        r = rows[i];
        check_value({row_name[i], " full"}, 32'(r.e_full), 32'(full));
        check_value({row_name[i], " dis_pos"}, 32'(r.e_dis_pos), 32'(dis_pos));
        if (r.c_wb) begin
            check_value({row_name[i], " wb_en"}, 32'(r.e_wb_en), 32'(wb_en));
            if (r.e_wb_en) begin
                check_value({row_name[i], " wb_idx"}, 32'(r.e_wb_idx), 32'(wb_idx));
                check_value({row_name[i], " wb_data"}, r.e_wb_data, wb_data);
            end
        end
        if (r.c_vio) begin
            check_value({row_name[i], " vio_en"}, 32'(r.e_vio_en), 32'(vio_en));
            if (r.e_vio_en) begin
                check_value({row_name[i], " vio_pos"}, 32'(r.e_vio_pos), 32'(vio_pos));
            end
        end
    endtask

    always @(posedge clk) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count > n_rows * 4 + 50) begin
            $display("The run went past its cycle limit without finishing the table.");
            $display("Simulation finished: FAIL");
            $fatal(1, "Timeout.");
        end
    end

    initial begin
        rst_n <= 1'b0;
        drive_row('0);
        build_table();
        repeat (3) @(posedge clk);
        rst_n <= 1'b1;
        for (int i = 0; i < n_rows; i++) begin
            @(posedge clk);
            drive_row(rows[i]);
            @(negedge clk); // Outputs have settled by the falling edge.
            check_row(i);
        end
        @(posedge clk);
        $display("Simulation finished: PASS");
        $finish;
    end

endmodule

`default_nettype wire
